/* dram_pkg.sv */
/*
 * DRAM line-fetch shared definitions
 * Widths, sizes, model latency, line data rule and the packed payloads
 * that travel between the clients, the arbiter and the DRAM model
 */
package dram_pkg;

	// =====================================================================
	// Sizes
	// =====================================================================
	localparam int ADDR_BW        = 16;
	localparam int DATA_BW        = 16;
	localparam int LINE_WORDS     = 4;
	// Reads the arbiter can track at once
	localparam int ARB_FIFO_SIZE  = 4;
	// Reads one client can have outstanding
	localparam int CLIENT_CREDITS = 2;
	// Fixed at two, the arbiter has one port pair per client
	localparam int N_CLIENTS      = 2;
	// Address acceptance to line rdy in the model
	localparam int DRAM_LATENCY   = 3;
	localparam logic [DATA_BW-1:0] LINE_SEED = 16'h5a5a;

	// Counter widths, derived
	localparam int ARB_CNT_BW    = $clog2(ARB_FIFO_SIZE + 1);
	localparam int CREDIT_BW     = $clog2(CLIENT_CREDITS + 1);

	// =====================================================================
	// Payloads
	// =====================================================================
	typedef struct packed {
		logic [ADDR_BW-1:0] addr;
	} dram_addr_t;

	// Word 0 sits in the low bits
	typedef struct packed {
		logic [LINE_WORDS-1:0][DATA_BW-1:0] word;
	} dram_line_t;

	// Line content rule: ((addr << 2) + k) truncated, then XOR seed
	function automatic dram_line_t make_line(input dram_addr_t a);
		dram_line_t l;
		for (int k = 0; k < LINE_WORDS; k++) begin
			l.word[k] = DATA_BW'({a.addr, 2'b00} + k) ^ LINE_SEED;
		end
		return l;
	endfunction

endpackage

/* rdyack_slice.sv */
/*
 * Ready/acknowledge register slice
 * One-entry stage that refills in the cycle its payload leaves
 */
`timescale 1ns/100ps
module rdyack_slice #(
	parameter type T = logic
) (
	input  logic i_clk,
	input  logic i_rst_n,
	// Upstream side
	input  logic i_rdy,
	output logic o_ack,
	input  T     i_data,
	// Downstream side
	output logic o_rdy,
	input  logic i_ack,
	output T     o_data
);

	// =====================================================================
	// State
	// =====================================================================
	logic full_r;
	logic in_xfer;

	// =====================================================================
	// Handshake
	// =====================================================================
	// Room when empty, or when the held entry leaves this cycle
	assign o_ack   = !full_r || i_ack;
	assign o_rdy   = full_r;
	assign in_xfer = i_rdy && o_ack;

	// Full flag follows the upstream rdy whenever a slot opens
	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			full_r <= 1'b0;
		end else if (o_ack) begin
			full_r <= i_rdy;
		end
	end

	// Payload register
	always_ff @(posedge i_clk) begin
		if (in_xfer) begin
			o_data <= i_data;
		end
	end

	// =====================================================================
	// Checks
	// =====================================================================
	// A stalled output holds both rdy and its payload
	a_hold_stable: assert property (
		@(posedge i_clk) disable iff (!i_rst_n)
		(o_rdy && !i_ack) |=> (o_rdy && $stable(o_data))
	);

endmodule

/* fetch_client.sv */
/*
 * Fetch client
 * Registers line-address requests toward the arbiter, limits reads in
 * flight with a credit counter and hands returning lines outward
 */
`timescale 1ns/100ps
module fetch_client (
	input  logic                 i_clk,
	input  logic                 i_rst_n,
	// Requests from outside
	input  logic                 i_req_rdy,
	output logic                 o_req_ack,
	input  dram_pkg::dram_addr_t i_req_addr,
	// Address toward the arbiter
	output logic                 o_dram_rdy,
	input  logic                 i_dram_ack,
	output dram_pkg::dram_addr_t o_dram_addr,
	// Lines from the arbiter
	input  logic                 i_line_rdy,
	output logic                 o_line_ack,
	input  dram_pkg::dram_line_t i_line,
	// Lines to outside
	output logic                 o_line_rdy,
	input  logic                 i_line_ack,
	output dram_pkg::dram_line_t o_line
);
	import dram_pkg::*;

	// =====================================================================
	// Internal
	// =====================================================================
	logic [CREDIT_BW-1:0] cnt_r;
	logic                 credit_ok;
	logic                 slice_rdy;
	logic                 slice_ack;
	logic                 req_xfer;
	logic                 line_xfer;

	assign credit_ok = cnt_r < CREDIT_BW'(CLIENT_CREDITS);
	// Slice only sees a request that already holds a credit
	assign slice_rdy = i_req_rdy && credit_ok;
	assign o_req_ack = credit_ok && slice_ack;
	assign req_xfer  = i_req_rdy && o_req_ack;

	// Responses pass straight through
	assign o_line_rdy = i_line_rdy;
	assign o_line_ack = i_line_ack;
	assign o_line     = i_line;
	assign line_xfer  = i_line_rdy && i_line_ack;

	// =====================================================================
	// Address stage
	// =====================================================================
	rdyack_slice #(.T(dram_addr_t)) addr_slice_i (
		.i_clk   (i_clk),
		.i_rst_n (i_rst_n),
		.i_rdy   (slice_rdy),
		.o_ack   (slice_ack),
		.i_data  (i_req_addr),
		.o_rdy   (o_dram_rdy),
		.i_ack   (i_dram_ack),
		.o_data  (o_dram_addr)
	);

	// =====================================================================
	// Credit counter
	// =====================================================================
	// Take on request, give back on delivery; both at once cancel
	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			cnt_r <= '0;
		end else if (req_xfer && !line_xfer) begin
			cnt_r <= cnt_r + CREDIT_BW'(1);
		end else if (line_xfer && !req_xfer) begin
			cnt_r <= cnt_r - CREDIT_BW'(1);
		end
	end

	a_credit_max: assert property (
		@(posedge i_clk) disable iff (!i_rst_n)
		cnt_r <= CREDIT_BW'(CLIENT_CREDITS)
	);

endmodule

/* dram_arbiter.sv */
/*
 * Two-way DRAM read arbiter
 * Round-robin grant of the shared address port and an owner FIFO that
 * steers each returning line to the client that asked for it
 */
`timescale 1ns/100ps
module dram_arbiter (
	input  logic                 i_clk,
	input  logic                 i_rst_n,
	// Client 0 address
	input  logic                 i_c0_rdy,
	output logic                 o_c0_ack,
	input  dram_pkg::dram_addr_t i_c0_addr,
	// Client 1 address
	input  logic                 i_c1_rdy,
	output logic                 o_c1_ack,
	input  dram_pkg::dram_addr_t i_c1_addr,
	// Lines toward the clients with a shared payload
	output logic                 o_c0_line_rdy,
	input  logic                 i_c0_line_ack,
	output logic                 o_c1_line_rdy,
	input  logic                 i_c1_line_ack,
	output dram_pkg::dram_line_t o_line,
	// DRAM read port
	output logic                 o_dram_rdy,
	input  logic                 i_dram_ack,
	output dram_pkg::dram_addr_t o_dram_addr,
	input  logic                 i_dram_line_rdy,
	output logic                 o_dram_line_ack,
	input  dram_pkg::dram_line_t i_dram_line
);
	import dram_pkg::*;

	// =====================================================================
	// Internal
	// =====================================================================
	// Round-robin priority bit that favours client 1 when set
	logic                     arb_r;
	// Selected client for this cycle
	logic                     sel;
	// Owner FIFO with bit i set when entry i belongs to client 1
	logic [ARB_FIFO_SIZE-1:0] own_r;
	logic [ARB_FIFO_SIZE-1:0] own_push;
	logic [ARB_CNT_BW-1:0]    n_r;
	logic [ARB_CNT_BW-1:0]    n_w;
	logic                     is_full;
	logic                     addr_xfer;
	logic                     line_xfer;

	// =====================================================================
	// Address side
	// =====================================================================
	assign is_full    = n_r == ARB_CNT_BW'(ARB_FIFO_SIZE);
	assign o_dram_rdy = (i_c0_rdy || i_c1_rdy) && !is_full;
	assign addr_xfer  = o_dram_rdy && i_dram_ack;
	// Favoured client wins if it asks, else the other one
	assign sel         = arb_r ? i_c1_rdy : !i_c0_rdy;
	assign o_dram_addr = sel ? i_c1_addr : i_c0_addr;
	assign o_c0_ack    = addr_xfer && !sel;
	assign o_c1_ack    = addr_xfer && sel;

	// =====================================================================
	// Line side
	// =====================================================================
	// FIFO head owns the returning line
	assign o_c0_line_rdy   = i_dram_line_rdy && !own_r[0];
	assign o_c1_line_rdy   = i_dram_line_rdy && own_r[0];
	assign o_dram_line_ack = own_r[0] ? i_c1_line_ack : i_c0_line_ack;
	assign o_line          = i_dram_line;
	assign line_xfer       = i_dram_line_rdy && o_dram_line_ack;

	// New owner lands at the tail, before any shift
	assign own_push = (addr_xfer && sel) ? (ARB_FIFO_SIZE'(1) << n_r) : '0;

	always_comb begin
		n_w = n_r;
		if (addr_xfer && !line_xfer) begin
			n_w = n_r + ARB_CNT_BW'(1);
		end else if (line_xfer && !addr_xfer) begin
			n_w = n_r - ARB_CNT_BW'(1);
		end
	end

	// =====================================================================
	// Registers
	// =====================================================================
	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			arb_r <= 1'b0;
			own_r <= '0;
			n_r   <= '0;
		end else begin
			// Loser of this grant gets priority next
			if (addr_xfer) begin
				arb_r <= !sel;
			end
			if (line_xfer) begin
				own_r <= (own_r | own_push) >> 1;
			end else begin
				own_r <= own_r | own_push;
			end
			n_r <= n_w;
		end
	end

	// =====================================================================
	// Checks
	// =====================================================================
	a_fifo_max: assert property (
		@(posedge i_clk) disable iff (!i_rst_n)
		n_r <= ARB_CNT_BW'(ARB_FIFO_SIZE)
	);

	// Grants only reach a requesting client, and never both
	a_ack_rdy: assert property (
		@(posedge i_clk) disable iff (!i_rst_n)
		(!o_c0_ack || i_c0_rdy) && (!o_c1_ack || i_c1_rdy) && !(o_c0_ack && o_c1_ack)
	);

endmodule

/* dram_model.sv */
/*
 * Behavioral DRAM read model
 * Fixed-latency in-order delay line, line data built from the address
 */
`timescale 1ns/100ps
module dram_model (
	input  logic                 i_clk,
	input  logic                 i_rst_n,
	// Address in
	input  logic                 i_addr_rdy,
	output logic                 o_addr_ack,
	input  dram_pkg::dram_addr_t i_addr,
	// Line out
	output logic                 o_line_rdy,
	input  logic                 i_line_ack,
	output dram_pkg::dram_line_t o_line
);
	import dram_pkg::*;

	// =====================================================================
	// Delay line
	// =====================================================================
	// Stage 0 takes the new read, last stage feeds the output slice
	logic       [DRAM_LATENCY-1:0] vld_r;
	dram_addr_t [DRAM_LATENCY-1:0] addr_r;
	dram_line_t                    head_line;
	logic                          head_ack;
	logic                          adv;
	logic                          addr_xfer;

	// Whole line moves together; a refused head freezes everything
	assign adv        = !vld_r[DRAM_LATENCY-1] || head_ack;
	assign o_addr_ack = adv;
	assign addr_xfer  = i_addr_rdy && o_addr_ack;
	assign head_line  = make_line(addr_r[DRAM_LATENCY-1]);

	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			vld_r <= '0;
		end else if (adv) begin
			vld_r <= {vld_r[DRAM_LATENCY-2:0], addr_xfer};
		end
	end

	// Address delay line qualified by vld_r
	always_ff @(posedge i_clk) begin
		if (adv) begin
			addr_r <= {addr_r[DRAM_LATENCY-2:0], i_addr};
		end
	end

	// =====================================================================
	// Output stage
	// =====================================================================
	// Counts as the last cycle of the latency
	rdyack_slice #(.T(dram_line_t)) line_slice_i (
		.i_clk   (i_clk),
		.i_rst_n (i_rst_n),
		.i_rdy   (vld_r[DRAM_LATENCY-1]),
		.o_ack   (head_ack),
		.i_data  (head_line),
		.o_rdy   (o_line_rdy),
		.i_ack   (i_line_ack),
		.o_data  (o_line)
	);

	// =====================================================================
	// Checks
	// =====================================================================
	// A held output line with a valid head blocks new addresses
	a_stall_hold: assert property (
		@(posedge i_clk) disable iff (!i_rst_n)
		(vld_r[DRAM_LATENCY-1] && o_line_rdy && !i_line_ack) |-> !o_addr_ack
	);

endmodule

/* dram_fetch_top.sv */
/*
 * DRAM line-fetch subsystem top
 * Fetch clients share one DRAM read port through the arbiter
 */
`timescale 1ns/100ps
module dram_fetch_top (
	input  logic                 i_clk,
	input  logic                 i_rst_n,
	input  logic                 i_req_rdy  [dram_pkg::N_CLIENTS],
	output logic                 o_req_ack  [dram_pkg::N_CLIENTS],
	input  dram_pkg::dram_addr_t i_req_addr [dram_pkg::N_CLIENTS],
	output logic                 o_line_rdy [dram_pkg::N_CLIENTS],
	input  logic                 i_line_ack [dram_pkg::N_CLIENTS],
	output dram_pkg::dram_line_t o_line     [dram_pkg::N_CLIENTS]
);
	import dram_pkg::*;

	// =====================================================================
	// Interconnect
	// =====================================================================
	// Client to arbiter addresses
	logic       c_addr_rdy [N_CLIENTS];
	logic       c_addr_ack [N_CLIENTS];
	dram_addr_t c_addr     [N_CLIENTS];
	// Arbiter to client lines, payload shared
	logic       c_line_rdy [N_CLIENTS];
	logic       c_line_ack [N_CLIENTS];
	dram_line_t arb_line;
	// Arbiter to model
	logic       m_addr_rdy;
	logic       m_addr_ack;
	dram_addr_t m_addr;
	logic       m_line_rdy;
	logic       m_line_ack;
	dram_line_t m_line;

	// =====================================================================
	// Clients
	// =====================================================================
	for (genvar c = 0; c < N_CLIENTS; c++) begin : g_client
		fetch_client fetch_client_i (
			.i_clk       (i_clk),
			.i_rst_n     (i_rst_n),
			.i_req_rdy   (i_req_rdy[c]),
			.o_req_ack   (o_req_ack[c]),
			.i_req_addr  (i_req_addr[c]),
			.o_dram_rdy  (c_addr_rdy[c]),
			.i_dram_ack  (c_addr_ack[c]),
			.o_dram_addr (c_addr[c]),
			.i_line_rdy  (c_line_rdy[c]),
			.o_line_ack  (c_line_ack[c]),
			.i_line      (arb_line),
			.o_line_rdy  (o_line_rdy[c]),
			.i_line_ack  (i_line_ack[c]),
			.o_line      (o_line[c])
		);
	end

	// =====================================================================
	// Shared port
	// =====================================================================
	dram_arbiter dram_arbiter_i (
		.i_clk           (i_clk),
		.i_rst_n         (i_rst_n),
		.i_c0_rdy        (c_addr_rdy[0]),
		.o_c0_ack        (c_addr_ack[0]),
		.i_c0_addr       (c_addr[0]),
		.i_c1_rdy        (c_addr_rdy[1]),
		.o_c1_ack        (c_addr_ack[1]),
		.i_c1_addr       (c_addr[1]),
		.o_c0_line_rdy   (c_line_rdy[0]),
		.i_c0_line_ack   (c_line_ack[0]),
		.o_c1_line_rdy   (c_line_rdy[1]),
		.i_c1_line_ack   (c_line_ack[1]),
		.o_line          (arb_line),
		.o_dram_rdy      (m_addr_rdy),
		.i_dram_ack      (m_addr_ack),
		.o_dram_addr     (m_addr),
		.i_dram_line_rdy (m_line_rdy),
		.o_dram_line_ack (m_line_ack),
		.i_dram_line     (m_line)
	);

	dram_model dram_model_i (
		.i_clk      (i_clk),
		.i_rst_n    (i_rst_n),
		.i_addr_rdy (m_addr_rdy),
		.o_addr_ack (m_addr_ack),
		.i_addr     (m_addr),
		.o_line_rdy (m_line_rdy),
		.i_line_ack (m_line_ack),
		.o_line     (m_line)
	);

endmodule

/* tb_dram_fetch.sv */
/*
 * DRAM line-fetch testbench
 * Replays request patterns on both clients, predicts every line from
 * the address rule and checks order, latency and credit back-pressure
 */
`timescale 1ns/100ps
module tb_dram_fetch;
	import dram_pkg::*;

	// =====================================================================
	// Constants and signals
	// =====================================================================
	localparam int PAT_MAX      = 64;
	localparam int PAT_COLS     = 5;
	localparam int RESET_CYCLES = 2;
	localparam int RAND_HOLD    = 15;
	localparam int LATENCY_TEST = 2;
	localparam int BURST_TEST   = 5;
	localparam logic [15:0] END_MARK = 16'hffff;

	logic       clk;
	logic       rst_n;
	logic       req_rdy  [N_CLIENTS];
	logic       req_ack  [N_CLIENTS];
	dram_addr_t req_addr [N_CLIENTS];
	logic       line_rdy [N_CLIENTS];
	logic       line_ack [N_CLIENTS];
	dram_line_t line     [N_CLIENTS];

	logic [15:0] pat_mem [PAT_MAX*PAT_COLS];
	// Per client: expected line, hold-off, request cycle (-1 skips latency)
	dram_line_t  exp_q  [N_CLIENTS][$];
	int          hold_q [N_CLIENTS][$];
	int          lat_q  [N_CLIENTS][$];
	int          stalls [N_CLIENTS];
	int          seed = 32'h8852628d;
	int          cyc = 0;
	int          errors = 0;
	int          pass_n = 0;
	int          fail_n = 0;

	dram_fetch_top dram_fetch_top_i (
		.i_clk      (clk),
		.i_rst_n    (rst_n),
		.i_req_rdy  (req_rdy),
		.o_req_ack  (req_ack),
		.i_req_addr (req_addr),
		.o_line_rdy (line_rdy),
		.i_line_ack (line_ack),
		.o_line     (line)
	);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	// Posedge readers see the count of earlier edges
	always @(posedge clk) cyc <= cyc + 1;

	// =====================================================================
	// Reference model and compares
	// =====================================================================
	// Word k = ((addr * 4) + k) mod 2^16, XOR seed
	function automatic dram_line_t expected_line(input logic [15:0] a);
		dram_line_t l;
		int v;
		for (int k = 0; k < LINE_WORDS; k++) begin
			v = (int'(a) * 4) + k;
			l.word[k] = v[15:0] ^ LINE_SEED;
		end
		return l;
	endfunction

	function automatic int pat_field(input int p, input int col);
		return int'(pat_mem[p*PAT_COLS + col]);
	endfunction

	task automatic check_line(input string name, input dram_line_t expected,
			input dram_line_t actual);
		if (actual !== expected) begin
			$display("mismatch at %0t: %s expected %h actual %h", $time, name, expected, actual);
			errors++;
		end
	endtask

	task automatic check_count(input string name, input int expected, input int actual);
		if (actual != expected) begin
			$display("mismatch at %0t: %s expected %0d actual %0d", $time, name, expected, actual);
			errors++;
		end
	endtask

	// =====================================================================
	// Drivers, sinks and watchdog
	// =====================================================================
	task automatic drive_requests(input int c, input int t);
		int hold;
		for (int p = 0; p < PAT_MAX && pat_mem[p*PAT_COLS] != END_MARK; p++) begin
			if (pat_field(p, 0) == t && pat_field(p, 1) == c) begin
				repeat (pat_field(p, 3)) @(negedge clk);
				req_rdy[c] = 1'b1;
				req_addr[c].addr = pat_mem[p*PAT_COLS + 2];
				// Transfer happens on the first edge that sees ack
				@(posedge clk);
				while (!req_ack[c]) begin
					stalls[c]++;
					@(posedge clk);
				end
				hold = pat_field(p, 4);
				if (hold == RAND_HOLD) begin
					hold = $random(seed) & 32'd3;
				end
				exp_q[c].push_back(expected_line(req_addr[c].addr));
				hold_q[c].push_back(hold);
				lat_q[c].push_back((t == LATENCY_TEST) ? cyc : -1);
				@(negedge clk);
				req_rdy[c] = 1'b0;
			end
		end
	endtask

	task automatic sink_lines(input int c);
		int held;
		int lat;
		held = 0;
		forever begin
			@(negedge clk);
			// Ack rises once the front line has waited out its hold-off
			line_ack[c] = (hold_q[c].size() != 0) && (held >= hold_q[c][0]);
			@(posedge clk);
			if (line_rdy[c] && line_ack[c]) begin
				if (exp_q[c].size() == 0) begin
					$display("client %0d delivered a line nobody asked for at %0t", c, $time);
					errors++;
				end else begin
					check_line($sformatf("o_line[%0d]", c), exp_q[c].pop_front(), line[c]);
					void'(hold_q[c].pop_front());
					lat = lat_q[c].pop_front();
					// Rdy rose one edge before it was first seen
					if (lat >= 0) begin
						check_count($sformatf("o_line_rdy[%0d] latency", c), 1 + DRAM_LATENCY,
							cyc - lat - 1);
					end
				end
				held = 0;
			end else if (line_rdy[c]) begin
				held++;
			end
		end
	endtask

	task automatic watch_run(input int limit);
		repeat (limit) @(posedge clk);
		$display("watchdog expired after %0d cycles, the run hung", limit);
		$display("Regression failed");
		$finish;
	endtask

	task automatic report_test(input int t, input int errs0);
		if (errors == errs0) begin
			pass_n++;
			$display("test %0d finished: ok", t);
		end else begin
			fail_n++;
			$display("test %0d finished: %0d errors", t, errors - errs0);
		end
	endtask

	task automatic run_test(input int t);
		int errs0;
		errs0 = errors;
		stalls[0] = 0;
		stalls[1] = 0;
		fork
			drive_requests(0, t);
			drive_requests(1, t);
		join
		while (exp_q[0].size() != 0 || exp_q[1].size() != 0) begin
			@(negedge clk);
		end
		// A burst over the credit limit must see the request ack drop
		if (t == BURST_TEST) begin
			check_count("o_req_ack[0] stalled", 1, int'(stalls[0] > 0));
		end
		report_test(t, errs0);
	endtask

	// =====================================================================
	// Sequence
	// =====================================================================
	initial begin
		int limit;
		int prev;
		int errs0;
		rst_n = 1'b0;
		for (int c = 0; c < N_CLIENTS; c++) begin
			req_rdy[c] = 1'b0;
			req_addr[c] = '0;
			line_ack[c] = 1'b0;
		end
		for (int i = 0; i < PAT_MAX*PAT_COLS; i++) begin
			pat_mem[i] = END_MARK;
		end
		$readmemh("dram_fetch_patterns.txt", pat_mem);
		// Budget per pattern is gap + hold-off + 20 cycles
		limit = RESET_CYCLES + 10;
		for (int p = 0; p < PAT_MAX && pat_mem[p*PAT_COLS] != END_MARK; p++) begin
			limit += pat_field(p, 3) + 20;
			limit += (pat_field(p, 4) == RAND_HOLD) ? 3 : pat_field(p, 4);
		end
		fork
			watch_run(limit);
			sink_lines(0);
			sink_lines(1);
		join_none
		repeat (RESET_CYCLES) @(negedge clk);
		rst_n = 1'b1;
		@(negedge clk);
		errs0 = errors;
		for (int c = 0; c < N_CLIENTS; c++) begin
			check_count($sformatf("o_line_rdy[%0d]", c), 0, int'(line_rdy[c]));
			check_count($sformatf("o_req_ack[%0d]", c), 1, int'(req_ack[c]));
		end
		report_test(1, errs0);
		prev = -1;
		for (int p = 0; p < PAT_MAX && pat_mem[p*PAT_COLS] != END_MARK; p++) begin
			if (pat_field(p, 0) != prev) begin
				prev = pat_field(p, 0);
				run_test(prev);
			end
		end
		$display("tests passed %0d, failed %0d", pass_n, fail_n);
		if (fail_n == 0 && errors == 0) begin
			$display("Regression passed");
		end else begin
			$display("Regression failed");
		end
		$finish;
	end

endmodule

/* dram_fetch.f */
dram_pkg.sv
rdyack_slice.sv
fetch_client.sv
dram_arbiter.sv
dram_model.sv
dram_fetch_top.sv
tb_dram_fetch.sv

/* run_sim.sh */
#!/bin/sh
# Build the dram_fetch testbench with Verilator, run it and scan the log
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --top-module tb_dram_fetch \
	-f dram_fetch.f -o tb_dram_fetch > build.log 2>&1 || { cat build.log; exit 1; }
./obj_dir/tb_dram_fetch > sim.log 2>&1
cat sim.log
grep -qx "Regression passed" sim.log && exit 0 || exit 1

/* dram_fetch_patterns.txt */
// Columns (hex): test, client, line address, issue gap cycles, ack hold-off cycles
// A hold-off of f draws a random hold-off of 0 to 3 cycles
2 0 0010 0 0
2 1 0020 c 0
3 0 0100 0 0
3 1 0200 0 0
3 0 0101 0 0
3 1 0201 0 0
3 0 0102 0 f
3 1 0202 0 f
3 0 0103 0 0
3 1 0203 0 0
4 0 0300 0 6
4 1 0400 0 0
4 0 0301 0 6
4 1 0401 0 f
4 0 0302 0 6
4 1 0402 0 0
5 0 fff0 0 2
5 0 fff1 0 2
5 0 fff2 0 2
5 0 fff3 0 2
